//--- compile.f
rtl/uart_rx_pkg.sv
rtl/uart_rx_ctrl.sv
rtl/uart_rx_datapath.sv
rtl/rx_fifo.sv
rtl/word_packer.sv
rtl/uart_word_rx.sv
sim/tb_uart_word_rx.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f compile.f --top-module tb_uart_word_rx; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_uart_word_rx)
run_status=$?
echo "$output"
if [ "$run_status" -ne 0 ]; then
    echo "simulation ended with an error"
    exit 1
fi

if echo "$output" | grep -q "Test OK"; then
    exit 0
fi
exit 1

//--- sim/tb_uart_word_rx.sv
`timescale 1ns/100ps
`default_nettype none

module tb_uart_word_rx;

    import uart_rx_pkg::*;

    localparam int FRAME_CYCLES   = 10 * CLKS_PER_BIT;
    localparam int TIMEOUT_CYCLES = 75 * FRAME_CYCLES; // 34 frames sent, the rest is margin.

    logic       clk;
    logic       reset_b;
    logic       rx;
    logic       word_ready;
    logic       word_valid;
    word_t      word_data;
    rx_status_t status;

    word_t      expected_words[$];
    word_t      next_word;
    int         next_lane;
    int         cycle_count;

    uart_word_rx uart_word_rx_i (
        .clk        (clk),
        .reset_b    (reset_b),
        .rx         (rx),
        .word_ready (word_ready),
        .word_valid (word_valid),
        .word_data  (word_data),
        .status     (status)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic report_failure(input string reason);
        $display("%s", reason);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("ERROR at %0t: %s is %h, expected %h",
                                     $time, name, got, exp));
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    // one 8N1 frame, lsb first; a low stop bit is followed by an idle bit.
    task automatic send_byte(input byte_t data, input logic stop_bit);
        rx = 1'b0;
        wait_cycles(CLKS_PER_BIT);
        for (int i = 0; i < 8; i++) begin
            rx = data[i];
            wait_cycles(CLKS_PER_BIT);
        end
        rx = stop_bit;
        wait_cycles(CLKS_PER_BIT);
        if (!stop_bit) begin
            rx = 1'b1;
            wait_cycles(CLKS_PER_BIT);
        end
    endtask

    // each byte goes into the next lane of the word it is expected in.
    task automatic send_good_bytes(input int count);
        byte_t data;
        for (int n = 0; n < count; n++) begin
            data = byte_t'($urandom);
            next_word[next_lane*8 +: 8] = data;
            next_lane++;
            if (next_lane == BYTES_PER_WORD) begin
                expected_words.push_back(next_word);
                next_lane = 0;
            end
            send_byte(data, 1'b1);
        end
    endtask

    task automatic wait_for_words();
        while (expected_words.size() != 0) begin
            wait_cycles(1);
        end
    endtask

    // scoreboard for accepted words.
    always @(posedge clk) begin
        if (reset_b && word_valid && word_ready) begin
            if (expected_words.size() == 0) begin
                report_failure("a word was accepted that no test expected");
            end else begin
                check_value("word_data", word_data, expected_words.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count == TIMEOUT_CYCLES) begin
            report_failure("timeout: the tests did not finish in time");
        end
    end

    initial begin
        void'($urandom(62));
        rx          = 1'b1;
        word_ready  = 1'b1;
        reset_b     = 1'b0;
        next_word   = '0;
        next_lane   = 0;
        cycle_count = 0;
        repeat (2) @(posedge clk);
        #1;
        reset_b = 1'b1;

        check_value("word_valid", 32'(word_valid), 32'd0);
        check_value("status.overrun", 32'(status.overrun), 32'd0);
        check_value("status.framing_error", 32'(status.framing_error), 32'd0);

        send_good_bytes(12); // three words in order.
        wait_for_words();
        check_value("status.overrun", 32'(status.overrun), 32'd0);
        check_value("status.framing_error", 32'(status.framing_error), 32'd0);

        send_byte(byte_t'($urandom), 1'b0);
        check_value("status.framing_error", 32'(status.framing_error), 32'd1);
        check_value("status.overrun", 32'(status.overrun), 32'd0);
        send_good_bytes(4);
        wait_for_words();

        // short low pulse must not look like a start bit.
        rx = 1'b0;
        wait_cycles(4);
        rx = 1'b1;
        wait_cycles(CLKS_PER_BIT);
        send_good_bytes(4);
        wait_for_words();

        // held word plus a full FIFO, so the 13th byte finds no credit.
        word_ready = 1'b0;
        send_good_bytes(12);
        send_byte(byte_t'($urandom), 1'b1);
        check_value("status.overrun", 32'(status.overrun), 32'd1);
        check_value("word_valid", 32'(word_valid), 32'd1);
        word_ready = 1'b1;
        wait_for_words();
        wait_cycles(FRAME_CYCLES); // time for a stray word to show up.
        check_value("status.framing_error", 32'(status.framing_error), 32'd1);

        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- rtl/uart_word_rx.sv
`timescale 1ns/100ps
`default_nettype none

module uart_word_rx (
    input  wire logic             clk,
    input  wire logic             reset_b,
    input  wire logic             rx,
    input  wire logic             word_ready,
    output logic                  word_valid,
    output uart_rx_pkg::word_t    word_data,
    output uart_rx_pkg::rx_status_t status
);

    import uart_rx_pkg::*;

    ctr_sel_e baud_sel;
    ctr_sel_e bit_sel;
    logic     shift_en;
    logic     baud_half_done;
    logic     baud_full_done;
    logic     last_bit;
    byte_t    rx_byte;
    rx_push_t push;
    logic     credit_return;
    logic     pop_valid;
    byte_t    pop_data;
    logic     pop_take;

    uart_rx_ctrl uart_rx_ctrl_i (
        .clk            (clk),
        .reset_b        (reset_b),
        .rx             (rx),
        .baud_half_done (baud_half_done),
        .baud_full_done (baud_full_done),
        .last_bit       (last_bit),
        .rx_byte        (rx_byte),
        .credit_return  (credit_return),
        .baud_sel       (baud_sel),
        .bit_sel        (bit_sel),
        .shift_en       (shift_en),
        .push           (push),
        .status         (status)
    );

    uart_rx_datapath uart_rx_datapath_i (
        .clk            (clk),
        .reset_b        (reset_b),
        .rx             (rx),
        .baud_sel       (baud_sel),
        .bit_sel        (bit_sel),
        .shift_en       (shift_en),
        .baud_half_done (baud_half_done),
        .baud_full_done (baud_full_done),
        .last_bit       (last_bit),
        .rx_byte        (rx_byte)
    );

    rx_fifo rx_fifo_i (
        .clk           (clk),
        .reset_b       (reset_b),
        .push          (push),
        .pop_take      (pop_take),
        .pop_valid     (pop_valid),
        .pop_data      (pop_data),
        .credit_return (credit_return)
    );

    word_packer word_packer_i (
        .clk        (clk),
        .reset_b    (reset_b),
        .pop_valid  (pop_valid),
        .pop_data   (pop_data),
        .word_ready (word_ready),
        .pop_take   (pop_take),
        .word_valid (word_valid),
        .word_data  (word_data)
    );

endmodule

`default_nettype wire

//--- rtl/word_packer.sv
`timescale 1ns/100ps
`default_nettype none

module word_packer (
    input  wire logic               clk,
    input  wire logic               reset_b,
    input  wire logic               pop_valid,
    input  wire uart_rx_pkg::byte_t pop_data,
    input  wire logic               word_ready,
    output logic                    pop_take,
    output logic                    word_valid,
    output uart_rx_pkg::word_t      word_data
);

    import uart_rx_pkg::*;

    logic [$clog2(BYTES_PER_WORD)-1:0] lane;

    // no taking while a finished word waits.
    assign pop_take = pop_valid && !word_valid;

    // first byte lands in the low lane.
    always_ff @(posedge clk) begin
        if (pop_take) begin
            word_data[lane*$bits(byte_t) +: $bits(byte_t)] <= pop_data;
        end
    end

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            lane       <= '0;
            word_valid <= 1'b0;
        end else if (word_valid) begin
            if (word_ready) begin
                word_valid <= 1'b0;
            end
        end else if (pop_take) begin
            lane <= lane + 1'b1; // wraps back to lane 0.
            if (lane == $bits(lane)'(BYTES_PER_WORD - 1)) begin
                word_valid <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/rx_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module rx_fifo (
    input  wire logic                  clk,
    input  wire logic                  reset_b,
    input  wire uart_rx_pkg::rx_push_t push,
    input  wire logic                  pop_take,
    output logic                       pop_valid,
    output uart_rx_pkg::byte_t         pop_data,
    output logic                       credit_return
);

    import uart_rx_pkg::*;

    byte_t                         mem [FIFO_DEPTH];
    logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr;
    logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr;
    credit_t                       count;
    logic                          pop;

    assign pop_valid = (count != '0);
    assign pop_data  = mem[rd_ptr];
    assign pop       = pop_valid && pop_take;

    // the sender holds credits, so a push always finds room.
    always_ff @(posedge clk) begin
        if (push.valid) begin
            mem[wr_ptr] <= push.data;
        end
    end

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            credit_return <= 1'b0;
        end else begin
            if (push.valid) begin
                wr_ptr <= wr_ptr + 1'b1; // depth is a power of two.
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push.valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            credit_return <= pop; // one pulse per freed entry.
        end
    end

endmodule

`default_nettype wire

//--- rtl/uart_rx_datapath.sv
`timescale 1ns/100ps
`default_nettype none

module uart_rx_datapath (
    input  wire logic                  clk,
    input  wire logic                  reset_b,
    input  wire logic                  rx,
    input  wire uart_rx_pkg::ctr_sel_e baud_sel,
    input  wire uart_rx_pkg::ctr_sel_e bit_sel,
    input  wire logic                  shift_en,
    output logic                       baud_half_done,
    output logic                       baud_full_done,
    output logic                       last_bit,
    output uart_rx_pkg::byte_t         rx_byte
);

    import uart_rx_pkg::*;

    baud_cnt_t baud_cnt;
    bit_cnt_t  bit_cnt;

    // shared next-count rule for both counters.
    function automatic baud_cnt_t ctr_next(ctr_sel_e sel, baud_cnt_t cnt);
        case (sel)
            ZERO:      return '0;
            INCREMENT: return cnt + 1'b1;
            default:   return cnt;
        endcase
    endfunction

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            baud_cnt <= '0;
            bit_cnt  <= '0;
        end else begin
            baud_cnt <= ctr_next(baud_sel, baud_cnt);
            bit_cnt  <= bit_cnt_t'(ctr_next(bit_sel, baud_cnt_t'(bit_cnt)));
        end
    end

    // the counter starts at zero one cycle after the edge or sample.
    assign baud_half_done = (baud_cnt == baud_cnt_t'(CLKS_PER_BIT / 2 - 1));

    // the sample state itself supplies the last clock of the bit.
    assign baud_full_done = (baud_cnt == baud_cnt_t'(CLKS_PER_BIT - 2));

    assign last_bit = (bit_cnt == bit_cnt_t'(7));

    // lsb arrives first and ends up in bit 0.
    always_ff @(posedge clk) begin
        if (shift_en) begin
            rx_byte <= {rx, rx_byte[7:1]};
        end
    end

endmodule

`default_nettype wire

//--- rtl/uart_rx_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module uart_rx_ctrl (
    input  wire logic                   clk,
    input  wire logic                   reset_b,
    input  wire logic                   rx,
    input  wire logic                   baud_half_done,
    input  wire logic                   baud_full_done,
    input  wire logic                   last_bit,
    input  wire uart_rx_pkg::byte_t     rx_byte,
    input  wire logic                   credit_return,
    output uart_rx_pkg::ctr_sel_e       baud_sel,
    output uart_rx_pkg::ctr_sel_e       bit_sel,
    output logic                        shift_en,
    output uart_rx_pkg::rx_push_t       push,
    output uart_rx_pkg::rx_status_t     status
);

    import uart_rx_pkg::*;

    rx_state_e state, next_state;
    credit_t   credits;
    logic      rx_prev;
    logic      push_now;

    // stop bit good and room left in the FIFO.
    assign push_now = (state == STOP_CHECK) && rx && (credits != '0);

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            state   <= IDLE;
            rx_prev <= 1'b1; // line idles high.
        end else begin
            state   <= next_state;
            rx_prev <= rx;
        end
    end

    always_comb begin
        next_state = state;
        baud_sel   = ZERO;
        bit_sel    = HOLD;
        shift_en   = 1'b0;
        case (state)
            IDLE: begin
                bit_sel = ZERO;
                if (rx_prev && !rx) next_state = START_CHECK; // falling edge.
            end
            START_CHECK: begin
                baud_sel = INCREMENT;
                if (baud_half_done) begin
                    baud_sel   = ZERO;
                    next_state = rx ? IDLE : DATA_WAIT; // high again means a glitch.
                end
            end
            DATA_WAIT: begin
                baud_sel = INCREMENT;
                if (baud_full_done) next_state = DATA_SAMPLE;
            end
            DATA_SAMPLE: begin
                shift_en   = 1'b1;
                bit_sel    = INCREMENT;
                next_state = last_bit ? STOP_WAIT : DATA_WAIT;
            end
            STOP_WAIT: begin
                baud_sel = INCREMENT;
                if (baud_full_done) next_state = STOP_CHECK;
            end
            STOP_CHECK: begin
                next_state = IDLE;
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    // one credit per push, one back per FIFO pop.
    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            credits <= credit_t'(FIFO_DEPTH);
        end else begin
            case ({push_now, credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            push.valid <= 1'b0;
            status     <= '0;
        end else begin
            push.valid <= push_now;
            if (push_now) begin
                push.data <= rx_byte;
            end
            if (state == STOP_CHECK && !rx) begin
                status.framing_error <= 1'b1;
            end
            if (state == STOP_CHECK && rx && credits == '0) begin
                status.overrun <= 1'b1; // line cannot stall, so the byte is lost.
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/uart_rx_pkg.sv
`default_nettype none

package uart_rx_pkg;

    localparam int CLKS_PER_BIT   = 16; // half a bit is 8 clocks.
    localparam int FIFO_DEPTH     = 8;
    localparam int BYTES_PER_WORD = 4;

    typedef logic [7:0]                  byte_t;
    typedef logic [BYTES_PER_WORD*8-1:0] word_t;
    typedef logic [3:0]                  credit_t; // counts 0 to FIFO_DEPTH.
    typedef logic [3:0]                  baud_cnt_t;
    typedef logic [2:0]                  bit_cnt_t;

    // action for the baud and bit counters.
    typedef enum logic [1:0] {
        ZERO      = 2'b00,
        HOLD      = 2'b10,
        INCREMENT = 2'b11
    } ctr_sel_e;

    typedef enum logic [2:0] {
        IDLE        = 3'd0,
        START_CHECK = 3'd1,
        DATA_WAIT   = 3'd2,
        DATA_SAMPLE = 3'd3,
        STOP_WAIT   = 3'd4,
        STOP_CHECK  = 3'd5
    } rx_state_e;

    typedef struct packed {
        logic  valid;
        byte_t data;
    } rx_push_t;

    typedef struct packed {
        logic overrun;       // byte lost for lack of credit.
        logic framing_error; // stop bit seen low.
    } rx_status_t;

endpackage

`default_nettype wire
